//--- design/dma_reg_pkg.sv
/* dma register map
   AXI4-Lite widths, response codes and control register fields */
package dma_reg_pkg;

	typedef logic [3:0]  axi_addr_t; // byte address within the window
	typedef logic [31:0] axi_data_t;
	typedef logic [1:0]  axi_resp_t;

	localparam axi_resp_t RESP_OKAY   = 2'b00;
	localparam axi_resp_t RESP_SLVERR = 2'b10;

	// register offsets
	localparam axi_addr_t REG_SADDR = 4'h0; // source word address
	localparam axi_addr_t REG_DADDR = 4'h4; // destination word address
	localparam axi_addr_t REG_LEN   = 4'h8; // words minus one
	localparam axi_addr_t REG_CTRL  = 4'hC; // launch on write, status on read

	// control register fields
	localparam int CTRL_ACT_BIT = 31; // read only
	localparam int CTRL_DIR_BIT = 7;  // 1 = RAM to device
	localparam int CTRL_DEV_MSB = 2;
	localparam int CTRL_DEV_LSB = 0;

endpackage

//--- design/dma_xfer_pkg.sv
/* dma transfer types
   data, address and length widths, device codes and sequencer states */
package dma_xfer_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;  // SD port width
	typedef logic [20:0] waddr_t; // DRAM word address
	typedef logic [7:0]  len_t;   // transfer moves len+1 words
	typedef logic [2:0]  dev_t;

	localparam dev_t DEV_RAM = 3'd1;
	localparam dev_t DEV_SD  = 3'd2;
	localparam dev_t DEV_IDE = 3'd3;

	typedef enum logic [1:0] {IDLE, RD, WR} seq_state_t;

	// memory owns both phases of a RAM copy, otherwise
	// the read phase for dir=1 and the write phase for dir=0
	function automatic logic mem_owns(dev_t dev, logic dir, seq_state_t st);
		return (dev == DEV_RAM) || (dir == (st == RD));
	endfunction

endpackage

//--- design/dma_regs.sv
/* dma register block
   AXI4-Lite slave for the setup registers, transfer launch and status */
`timescale 1ns/1ns
module dma_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dma_reg_pkg::axi_addr_t awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  dma_reg_pkg::axi_data_t wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output dma_reg_pkg::axi_resp_t bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  dma_reg_pkg::axi_addr_t araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output dma_reg_pkg::axi_data_t rdata,
	output dma_reg_pkg::axi_resp_t rresp,
	output logic                   rvalid,
	input  logic                   rready,
	input  logic                   active,
	output logic                   launch,
	output dma_xfer_pkg::waddr_t   saddr,
	output dma_xfer_pkg::waddr_t   daddr,
	output dma_xfer_pkg::len_t     len,
	output dma_xfer_pkg::dev_t     dev,
	output logic                   dir
);
	import dma_reg_pkg::*;
	import dma_xfer_pkg::*;

	logic      wr_hs;
	logic      wr_err;
	axi_data_t wr_mask;
	axi_data_t wr_val; // addressed register merged with strobed bytes
	dev_t      wr_dev;

	function automatic logic reg_hit(axi_addr_t a);
		return a inside {REG_SADDR, REG_DADDR, REG_LEN, REG_CTRL};
	endfunction

	function automatic axi_data_t reg_value(axi_addr_t a);
		axi_data_t v;
		v = '0;
		case (a)
			REG_SADDR: v = axi_data_t'(saddr);
			REG_DADDR: v = axi_data_t'(daddr);
			REG_LEN:   v = axi_data_t'(len);
			REG_CTRL:
			begin
				v[CTRL_ACT_BIT] = active;
				v[CTRL_DIR_BIT] = dir;
				v[CTRL_DEV_MSB:CTRL_DEV_LSB] = dev;
			end
			default:   v = '0;
		endcase
		return v;
	endfunction

	assign wr_hs = awready && awvalid && wvalid;

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			wr_mask[8*i +: 8] = {8{wstrb[i]}};
		wr_val = (reg_value(awaddr) & ~wr_mask) | (wdata & wr_mask);
		wr_dev = wr_val[CTRL_DEV_MSB:CTRL_DEV_LSB];
		// setup is locked while a transfer runs
		wr_err = active || !reg_hit(awaddr) ||
			(awaddr == REG_CTRL && !(wr_dev inside {DEV_RAM, DEV_SD, DEV_IDE}));
	end

	assign launch = wr_hs && !wr_err && (awaddr == REG_CTRL);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			arready <= 1'b0;
			rvalid  <= 1'b0;
			dev     <= '0;
			dir     <= 1'b0;
		end
		else
		begin
			awready <= awvalid && wvalid && !awready && !bvalid; // one cycle pulse
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			arready <= arvalid && !arready && !rvalid;
			if (arready && arvalid)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (launch)
			begin
				dev <= wr_dev;
				dir <= wr_val[CTRL_DIR_BIT];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_hs)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		if (wr_hs && !wr_err)
		begin
			case (awaddr)
				REG_SADDR: saddr <= waddr_t'(wr_val);
				REG_DADDR: daddr <= waddr_t'(wr_val);
				REG_LEN:   len   <= len_t'(wr_val);
				default:   ; // CTRL handled with launch
			endcase
		end
		if (arready && arvalid)
		begin
			rdata <= reg_value(araddr);
			rresp <= reg_hit(araddr) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// launch only from idle, and the sequencer picks it up
	assert property (@(posedge clk) disable iff (!rst_n) launch |=> $rose(active))
		else $error("launch while active or not taken by the sequencer");
	assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("write response changed before bready");

endmodule

//--- design/dma_mem_port.sv
/* dma DRAM port
   issues DRAM requests and steps the source and destination counters */
`timescale 1ns/1ns
module dma_mem_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     launch,
	input  dma_xfer_pkg::waddr_t     saddr,
	input  dma_xfer_pkg::waddr_t     daddr,
	input  dma_xfer_pkg::dev_t       dev,
	input  logic                     dir,
	input  dma_xfer_pkg::seq_state_t state,
	output dma_xfer_pkg::waddr_t     dram_addr,
	output dma_xfer_pkg::word_t      dram_wrdata,
	output logic                     dram_req,
	output logic                     dram_rnw,
	input  logic                     dram_next,
	input  dma_xfer_pkg::word_t      dram_rddata,
	input  logic                     dram_stb,
	input  dma_xfer_pkg::word_t      wr_word,
	output dma_xfer_pkg::word_t      rd_word,
	output logic                     rd_word_valid,
	output logic                     mem_phase_end
);
	import dma_xfer_pkg::*;

	waddr_t src;
	waddr_t dst;
	logic   own;
	logic   rd_pend; // read accepted, data not back yet
	logic   accept;

	assign own           = (state != IDLE) && mem_owns(dev, dir, state);
	assign dram_rnw      = (state == RD);
	assign dram_req      = own && !rd_pend;
	assign dram_addr     = dram_rnw ? src : dst;
	assign dram_wrdata   = wr_word;
	assign accept        = dram_req && dram_next;
	assign rd_word       = dram_rddata;
	assign rd_word_valid = rd_pend && dram_stb;
	assign mem_phase_end = rd_word_valid || (accept && !dram_rnw); // reads end at stb

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rd_pend <= 1'b0;
		else if (accept && dram_rnw)
			rd_pend <= 1'b1;
		else if (dram_stb)
			rd_pend <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			src <= saddr;
			dst <= daddr;
		end
		else if (accept && dram_rnw)
			src <= src + 1'b1;
		else if (accept)
			dst <= dst + 1'b1;
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		dram_req && !dram_next |=> dram_req && $stable(dram_addr))
		else $error("DRAM request changed before dram_next");

endmodule

//--- design/dma_dev_port.sv
/* dma device port
   routes requests to the SD or IDE port and holds the word in flight */
`timescale 1ns/1ns
module dma_dev_port (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     launch,
	input  dma_xfer_pkg::dev_t       dev,
	input  logic                     dir,
	input  dma_xfer_pkg::seq_state_t state,
	input  dma_xfer_pkg::byte_t      sd_rddata,
	output dma_xfer_pkg::byte_t      sd_wrdata,
	output logic                     sd_req,
	output logic                     sd_rnw,
	input  logic                     sd_stb,
	input  dma_xfer_pkg::word_t      ide_rddata,
	output dma_xfer_pkg::word_t      ide_wrdata,
	output logic                     ide_req,
	output logic                     ide_rnw,
	input  logic                     ide_stb,
	input  dma_xfer_pkg::word_t      rd_word,
	input  logic                     rd_word_valid,
	output dma_xfer_pkg::word_t      wr_word,
	output logic                     dev_phase_end
);
	import dma_xfer_pkg::*;

	word_t data;
	logic  bsel; // 0 = low byte, 1 = high byte
	logic  own;
	logic  rnw;
	logic  sd_hit;
	logic  ide_hit;

	assign own        = (state != IDLE) && !mem_owns(dev, dir, state);
	assign rnw        = (state == RD);
	assign sd_req     = own && (dev == DEV_SD);
	assign ide_req    = own && (dev == DEV_IDE);
	assign sd_rnw     = rnw;
	assign ide_rnw    = rnw;
	assign sd_wrdata  = bsel ? data[15:8] : data[7:0];
	assign ide_wrdata = data;
	assign wr_word    = data;

	assign sd_hit        = sd_req && sd_stb;
	assign ide_hit       = ide_req && ide_stb;
	assign dev_phase_end = (sd_hit && bsel) || ide_hit; // SD ends on second byte

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			bsel <= 1'b0;
		else if (launch)
			bsel <= 1'b0;
		else if (sd_hit)
			bsel <= ~bsel;
	end

	always_ff @(posedge clk)
	begin
		if (rd_word_valid)
			data <= rd_word; // from DRAM
		else if (sd_hit && rnw)
		begin
			if (bsel)
				data[15:8] <= sd_rddata;
			else
				data[7:0] <= sd_rddata;
		end
		else if (ide_hit && rnw)
			data <= ide_rddata;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(sd_req && ide_req))
		else $error("SD and IDE requested together");
	assert property (@(posedge clk) disable iff (!rst_n)
		sd_req && !sd_stb |=> sd_req && $stable(bsel))
		else $error("SD request or byte select moved without a strobe");

endmodule

//--- design/dma_sequencer.sv
/* dma sequencer
   alternates read and write phases and counts words to the done pulse */
`timescale 1ns/1ns
module dma_sequencer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     launch,
	input  dma_xfer_pkg::len_t       len,
	input  dma_xfer_pkg::dev_t       dev,
	input  logic                     dir,
	input  logic                     mem_phase_end,
	input  logic                     dev_phase_end,
	output dma_xfer_pkg::seq_state_t state,
	output logic                     active,
	output logic                     dma_done
);
	import dma_xfer_pkg::*;

	len_t left; // words remaining after the current one
	logic phase_end;
	logic last;

	assign phase_end = mem_owns(dev, dir, state) ? mem_phase_end : dev_phase_end;
	assign last      = (state == WR) && phase_end && (left == '0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state    <= IDLE;
			active   <= 1'b0;
			dma_done <= 1'b0;
		end
		else
		begin
			dma_done <= last;
			case (state)
				IDLE:
					if (launch)
					begin
						state  <= RD;
						active <= 1'b1;
					end
				RD:
					if (phase_end)
						state <= WR;
				WR:
					if (last)
					begin
						state  <= IDLE;
						active <= 1'b0;
					end
					else if (phase_end)
						state <= RD; // next word
				default:
				begin
					state  <= IDLE;
					active <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			left <= len;
		else if ((state == WR) && phase_end)
			left <= left - 1'b1;
	end

	assert property (@(posedge clk) disable iff (!rst_n) (state == IDLE) == !active)
		else $error("active flag out of step with sequencer state");

endmodule

//--- design/dma_top.sv
/* dma controller top
   register block, DRAM port, device port and sequencer */
`timescale 1ns/1ns
module dma_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  dma_reg_pkg::axi_addr_t awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  dma_reg_pkg::axi_data_t wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output dma_reg_pkg::axi_resp_t bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  dma_reg_pkg::axi_addr_t araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output dma_reg_pkg::axi_data_t rdata,
	output dma_reg_pkg::axi_resp_t rresp,
	output logic                   rvalid,
	input  logic                   rready,
	output dma_xfer_pkg::waddr_t   dram_addr,
	output dma_xfer_pkg::word_t    dram_wrdata,
	output logic                   dram_req,
	output logic                   dram_rnw,
	input  logic                   dram_next,
	input  dma_xfer_pkg::word_t    dram_rddata,
	input  logic                   dram_stb,
	input  dma_xfer_pkg::byte_t    sd_rddata,
	output dma_xfer_pkg::byte_t    sd_wrdata,
	output logic                   sd_req,
	output logic                   sd_rnw,
	input  logic                   sd_stb,
	input  dma_xfer_pkg::word_t    ide_rddata,
	output dma_xfer_pkg::word_t    ide_wrdata,
	output logic                   ide_req,
	output logic                   ide_rnw,
	input  logic                   ide_stb,
	output logic                   dma_done
);
	import dma_xfer_pkg::*;

	logic       launch;
	logic       active;
	waddr_t     saddr;
	waddr_t     daddr;
	len_t       len;
	dev_t       dev;
	logic       dir;
	seq_state_t state;
	word_t      rd_word;  // DRAM read data into the holding register
	logic       rd_word_valid;
	word_t      wr_word;  // holding register out to DRAM
	logic       mem_phase_end;
	logic       dev_phase_end;

	dma_regs      dma_regs_i      (.*);
	dma_mem_port  dma_mem_port_i  (.*);
	dma_dev_port  dma_dev_port_i  (.*);
	dma_sequencer dma_sequencer_i (.*);

endmodule

//--- verification/dma_tb.sv
/* dma controller testbench
   AXI4-Lite host, DRAM, SD and IDE models, and a table of transfers */
`timescale 1ns/1ns
module dma_tb;
	import dma_reg_pkg::*;
	import dma_xfer_pkg::*;

	typedef struct packed {
		dev_t   dev;
		logic   dir;
		waddr_t saddr;
		waddr_t daddr;
		len_t   len;
	} xfer_t;

	localparam int NROWS     = 7;
	localparam int MEM_WORDS = 4096;
	localparam int SRC_LEN   = 512; // device source depth

	// device, direction, source, destination, words minus one
	xfer_t xfers [0:NROWS-1] = '{
		'{DEV_RAM, 1'b0, 21'd16,   21'd600,  8'd15},
		'{DEV_SD,  1'b0, 21'd0,    21'd1000, 8'd7},
		'{DEV_SD,  1'b1, 21'd200,  21'd0,    8'd5},
		'{DEV_IDE, 1'b0, 21'd0,    21'd1500, 8'd20},
		'{DEV_IDE, 1'b1, 21'd300,  21'd0,    8'd31},
		'{DEV_RAM, 1'b1, 21'd2000, 21'd2100, 8'd0},  // dir ignored for RAM
		'{DEV_RAM, 1'b0, 21'd3000, 21'd3500, 8'd255}
	};

	logic      clk   = 1'b0;
	logic      rst_n = 1'b0;
	axi_addr_t awaddr;
	axi_addr_t araddr;
	axi_data_t wdata;
	axi_data_t rdata;
	axi_resp_t bresp;
	axi_resp_t rresp;
	logic [3:0] wstrb;
	logic      awvalid, awready, wvalid, wready, bvalid, bready;
	logic      arvalid, arready, rvalid, rready;
	waddr_t    dram_addr;
	word_t     dram_wrdata;
	word_t     dram_rddata = '0;
	logic      dram_req, dram_rnw;
	logic      dram_next = 1'b0;
	logic      dram_stb  = 1'b0;
	byte_t     sd_rddata = '0;
	byte_t     sd_wrdata;
	logic      sd_req, sd_rnw;
	logic      sd_stb = 1'b0;
	word_t     ide_rddata = '0;
	word_t     ide_wrdata;
	logic      ide_req, ide_rnw;
	logic      ide_stb = 1'b0;
	logic      dma_done;

	integer seed = 32'h14175802;
	word_t  dram [0:MEM_WORDS-1];
	word_t  exp_dram [0:MEM_WORDS-1]; // expected DRAM after each row
	byte_t  sd_src [0:SRC_LEN-1];
	word_t  ide_src [0:SRC_LEN-1];
	byte_t  sd_sink [$];
	word_t  ide_sink [$];
	int     sd_ptr    = 0;
	int     ide_ptr   = 0;
	int     done_cnt  = 0;
	int     dram_wait = 0;
	int     dev_wait  = 0;
	int     acc_addr  = 0;
	logic   acc_rnw   = 1'b0;
	word_t  acc_data  = '0;

	dma_top dma_top_i (.*);

	always #10 clk = ~clk;

	// DRAM, SD and IDE models sharing one stall generator
	always @(negedge clk)
	begin
		if (dma_done === 1'b1)
			done_cnt++;
		dram_stb = 1'b0;
		if (dram_next)
		begin
			dram_next = 1'b0; // request taken on the last rising edge
			if (acc_rnw)
			begin
				dram_rddata = dram[acc_addr];
				dram_stb    = 1'b1;
			end
			else
				dram[acc_addr] = acc_data;
			dram_wait = $random(seed) & 3;
		end
		else if (dram_req === 1'b1)
		begin
			if (dram_wait > 0)
				dram_wait--;
			else
			begin
				dram_next = 1'b1;
				acc_addr  = int'(dram_addr) % MEM_WORDS;
				acc_rnw   = dram_rnw;
				acc_data  = dram_wrdata;
			end
		end
		if (sd_stb || ide_stb)
		begin
			sd_stb  = 1'b0;
			ide_stb = 1'b0;
		end
		else if (sd_req === 1'b1 || ide_req === 1'b1)
		begin
			if (dev_wait > 0)
				dev_wait--;
			else
			begin
				if (sd_req && sd_rnw)
				begin
					sd_rddata = sd_src[sd_ptr];
					sd_ptr++;
				end
				else if (sd_req)
					sd_sink.push_back(sd_wrdata);
				else if (ide_rnw)
				begin
					ide_rddata = ide_src[ide_ptr];
					ide_ptr++;
				end
				else
					ide_sink.push_back(ide_wrdata);
				sd_stb   = sd_req;
				ide_stb  = ide_req;
				dev_wait = $random(seed) & 3;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
			$display(">>> FAIL");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic write_reg(input axi_addr_t addr, input axi_data_t data,
		output axi_resp_t resp);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		check_value("wready", wready, 1'b1); // pulses with awready
		@(negedge clk); // handshake on the edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge clk);
		resp   = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input axi_addr_t addr, output axi_data_t data,
		output axi_resp_t resp);
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic program_reg(input axi_addr_t addr, input axi_data_t value,
		input string name);
		axi_data_t rd;
		axi_resp_t resp;
		write_reg(addr, value, resp);
		check_value({name, " bresp"}, resp, RESP_OKAY);
		read_reg(addr, rd, resp);
		check_value({name, " rresp"}, resp, RESP_OKAY);
		check_value({name, " readback"}, rd, value);
	endtask

	task automatic run_transfer(input xfer_t x);
		axi_data_t rd;
		axi_data_t ctrl;
		axi_resp_t resp;
		word_t     src_w;
		int        n;
		int        start;
		int        sd_first;
		int        ide_first;
		n = int'(x.len) + 1;
		program_reg(REG_SADDR, axi_data_t'(x.saddr), "saddr");
		program_reg(REG_DADDR, axi_data_t'(x.daddr), "daddr");
		program_reg(REG_LEN, axi_data_t'(x.len), "len");
		exp_dram = dram;
		sd_sink.delete();
		ide_sink.delete();
		sd_first  = sd_ptr;
		ide_first = ide_ptr;
		for (int i = 0; i < n; i++)
		begin
			if (x.dev == DEV_RAM)
				exp_dram[(int'(x.daddr) + i) % MEM_WORDS] =
					exp_dram[(int'(x.saddr) + i) % MEM_WORDS];
			else if (!x.dir && x.dev == DEV_SD)
				exp_dram[(int'(x.daddr) + i) % MEM_WORDS] =
					{sd_src[sd_first + 2*i + 1], sd_src[sd_first + 2*i]}; // low byte first
			else if (!x.dir)
				exp_dram[(int'(x.daddr) + i) % MEM_WORDS] = ide_src[ide_first + i];
		end
		ctrl = '0;
		ctrl[CTRL_DIR_BIT] = x.dir;
		ctrl[CTRL_DEV_MSB:CTRL_DEV_LSB] = x.dev;
		start = done_cnt;
		write_reg(REG_CTRL, ctrl, resp);
		check_value("ctrl bresp", resp, RESP_OKAY);
		if (x.len >= 8'd15)
		begin
			write_reg(REG_SADDR, 32'h1F0, resp); // still running here
			check_value("bresp while active", resp, RESP_SLVERR);
		end
		while (done_cnt == start)
			@(negedge clk);
		read_reg(REG_CTRL, rd, resp);
		check_value("ctrl rresp", resp, RESP_OKAY);
		check_value("active after done", rd[CTRL_ACT_BIT], 1'b0);
		check_value("done pulses", done_cnt - start, 1);
		read_reg(REG_SADDR, rd, resp);
		check_value("saddr after locked write", rd, axi_data_t'(x.saddr));
		for (int a = 0; a < MEM_WORDS; a++)
			check_value($sformatf("dram[%0d]", a), dram[a], exp_dram[a]);
		check_value("sd bytes taken", sd_ptr - sd_first,
			(x.dev == DEV_SD && !x.dir) ? 2*n : 0);
		check_value("ide words taken", ide_ptr - ide_first,
			(x.dev == DEV_IDE && !x.dir) ? n : 0);
		check_value("sd bytes sent", sd_sink.size(), (x.dev == DEV_SD && x.dir) ? 2*n : 0);
		check_value("ide words sent", ide_sink.size(), (x.dev == DEV_IDE && x.dir) ? n : 0);
		for (int i = 0; i < sd_sink.size(); i++)
		begin
			src_w = exp_dram[(int'(x.saddr) + i / 2) % MEM_WORDS];
			check_value($sformatf("sd byte %0d", i), sd_sink[i],
				i[0] ? src_w[15:8] : src_w[7:0]);
		end
		for (int i = 0; i < ide_sink.size(); i++)
			check_value($sformatf("ide word %0d", i), ide_sink[i],
				exp_dram[(int'(x.saddr) + i) % MEM_WORDS]);
	endtask

	initial
	begin
		axi_data_t rd;
		axi_resp_t resp;
		int        done_before;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		for (int i = 0; i < MEM_WORDS; i++)
			dram[i] = word_t'($random(seed));
		for (int i = 0; i < SRC_LEN; i++)
		begin
			sd_src[i]  = byte_t'($random(seed));
			ide_src[i] = word_t'($random(seed));
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("dram_req after reset", dram_req, 1'b0);
		check_value("sd_req after reset", sd_req, 1'b0);
		check_value("ide_req after reset", ide_req, 1'b0);
		check_value("dma_done after reset", dma_done, 1'b0);
		read_reg(REG_CTRL, rd, resp);
		check_value("ctrl rresp after reset", resp, RESP_OKAY);
		check_value("active after reset", rd[CTRL_ACT_BIT], 1'b0);
		read_reg(4'h2, rd, resp); // between SADDR and DADDR
		check_value("rresp for unmapped address", resp, RESP_SLVERR);
		for (int r = 0; r < NROWS; r++)
			run_transfer(xfers[r]);
		// device code 5 is refused
		done_before = done_cnt;
		write_reg(REG_CTRL, 32'h0000_0005, resp);
		check_value("bresp for device 5", resp, RESP_SLVERR);
		repeat (8) @(negedge clk);
		read_reg(REG_CTRL, rd, resp);
		check_value("active after device 5", rd[CTRL_ACT_BIT], 1'b0);
		check_value("device field after device 5", rd[CTRL_DEV_MSB:CTRL_DEV_LSB],
			xfers[NROWS-1].dev);
		check_value("dram_req after device 5", dram_req, 1'b0);
		check_value("done pulses after device 5", done_cnt, done_before);
		$display(">>> PASS");
		$finish;
	end

	// 40 cycles per word plus room for reset and register traffic
	initial
	begin
		int words;
		words = 0;
		for (int i = 0; i < NROWS; i++)
			words += int'(xfers[i].len) + 1;
		repeat (words * 40 + 1000) @(posedge clk);
		$display("timeout: test did not finish within %0d cycles", words * 40 + 1000);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

//--- tb.f
design/dma_reg_pkg.sv
design/dma_xfer_pkg.sv
design/dma_regs.sv
design/dma_mem_port.sv
design/dma_dev_port.sv
design/dma_sequencer.sv
design/dma_top.sv
verification/dma_tb.sv

//--- Makefile
# Verilator lint and simulation of the DMA controller

VERILATOR ?= verilator
FILELIST  ?= tb.f
TOP       ?= dma_tb
RTL_TOP   ?= dma_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

RTL_SRCS := $(shell grep '^design/' $(FILELIST))
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
